// File: project.f
+incdir+rtl
rtl/joybus_pkg.sv
rtl/joybus_crc.sv
rtl/joybus_rx.sv
rtl/joybus_tx.sv
rtl/fake_n64_controller.sv
tb/fake_n64_controller_assert.sv
tb/fake_n64_controller_tb.sv

// File: rtl/fake_n64_controller.sv
`timescale 1ns/1ps

module fake_n64_controller (
    input  logic        sample_clk,
    input  logic        crc_reset,
    input  logic        joy_in,
    input  logic [31:0] buttons,
    output logic        joy_out,
    output logic        joy_drive
);
    import joybus_pkg::*;

    logic        cur_operation; // high while tx owns the line
    joybus_cmd_e cmd;
    crc_t        crc;           // write data remainder, pre-flush
    logic        rx_handoff;    // toggles once per finished reply

    joybus_rx rx0 (
        .sample_clk    (sample_clk),
        .crc_reset     (crc_reset),
        .joy_in        (joy_in),
        .rx_handoff    (rx_handoff),
        .cur_operation (cur_operation),
        .cmd           (cmd),
        .crc           (crc)
    );

    joybus_tx tx0 (
        .sample_clk    (sample_clk),
        .crc_reset     (crc_reset),
        .cur_operation (cur_operation),
        .cmd           (cmd),
        .crc           (crc),
        .buttons       (buttons),
        .rx_handoff    (rx_handoff),
        .joy_out       (joy_out),
        .joy_drive     (joy_drive)
    );

endmodule

// File: rtl/joybus_config.svh
`ifndef JOYBUS_CONFIG_SVH
`define JOYBUS_CONFIG_SVH

// line timing, in sample_clk cycles
`define JOYBUS_LEVEL_WIDTH 2
`define JOYBUS_BIT_WIDTH (4 * `JOYBUS_LEVEL_WIDTH)
`define JOYBUS_SAMPLE_POINT (2 * `JOYBUS_LEVEL_WIDTH) // after the falling edge

// x^8 + x^7 + x^2 + 1, top term implied
`define JOYBUS_CRC_POLY 8'h85

// frame field lengths, in bits
`define JOYBUS_ADDR_BITS 16
`define JOYBUS_WRITE_DATA_BITS 256
`define JOYBUS_READ_RESP_BITS 264

`endif

// File: rtl/joybus_crc.sv
`timescale 1ns/1ps

`include "joybus_config.svh"

module joybus_crc (
    input  logic              sample_clk,
    input  logic              crc_reset,
    input  joybus_pkg::crc_t  reset_to,
    input  logic              load,
    input  logic              enable,
    input  logic              data,
    output joybus_pkg::crc_t  rem
);
    import joybus_pkg::*;

    crc_t next_rem;

    // shift left, data enters at bit 0, fold poly on carry out
    always_comb begin
        next_rem = {rem[6:0], data};
        if (rem[7]) begin
            next_rem = next_rem ^ `JOYBUS_CRC_POLY;
        end
    end

    always_ff @(posedge sample_clk) begin
        if (crc_reset) begin
            rem <= '0;
        end else if (load) begin
            rem <= reset_to; // seed wins over a step
        end else if (enable) begin
            rem <= next_rem;
        end
    end

endmodule

// File: rtl/joybus_pkg.sv
package joybus_pkg;

    // console command codes
    typedef enum logic [7:0] {
        CMD_INFO   = 8'h00,
        CMD_STATUS = 8'h01,
        CMD_READ   = 8'h02,
        CMD_WRITE  = 8'h03,
        CMD_RESET  = 8'hff
    } joybus_cmd_e;

    typedef enum logic [1:0] {
        RX_IDLE   = 2'd0, // waiting for a falling edge
        RX_SAMPLE = 2'd1, // counting to mid-bit
        RX_BUSY   = 2'd2  // transmitter owns the line
    } rx_state_e;

    typedef enum logic [1:0] {
        PREPPING_RESPONSE = 2'd0,
        SENDING_LEVELS    = 2'd1,
        FLUSH_CRC         = 2'd2
    } tx_state_e;

    typedef logic [7:0] crc_t;

endpackage

// File: rtl/joybus_rx.sv
`timescale 1ns/1ps

`include "joybus_config.svh"

module joybus_rx (
    input  logic                    sample_clk,
    input  logic                    crc_reset,
    input  logic                    joy_in,
    input  logic                    rx_handoff,
    output logic                    cur_operation,
    output joybus_pkg::joybus_cmd_e cmd,
    output joybus_pkg::crc_t        crc
);
    import joybus_pkg::*;

    localparam int CNT_W = $clog2(8 + `JOYBUS_ADDR_BITS + `JOYBUS_WRITE_DATA_BITS + 2);
    localparam int SMP_W = $clog2(`JOYBUS_SAMPLE_POINT + 1);
    localparam logic [CNT_W-1:0] CMD_BITS = CNT_W'(8);
    localparam logic [CNT_W-1:0] READ_FRAME = CNT_W'(8 + `JOYBUS_ADDR_BITS);
    localparam logic [CNT_W-1:0] WRITE_FRAME =
        CNT_W'(8 + `JOYBUS_ADDR_BITS + `JOYBUS_WRITE_DATA_BITS);
    localparam logic [SMP_W-1:0] SAMPLE_AT = SMP_W'(`JOYBUS_SAMPLE_POINT);

    rx_state_e        state;
    logic             joy_meta;
    logic             joy_sync;
    logic             joy_prev;
    logic             fall_edge;
    logic             sample_now;
    logic [SMP_W-1:0] sample_cnt;
    logic [CNT_W-1:0] bit_cnt;
    logic [CNT_W-1:0] frame_len;
    logic [7:0]       cmd_byte;
    logic             cmd_known;
    logic             handoff_seen;
    logic             crc_load;
    logic             crc_enable;

    // two-flop synchronizer plus one more for edge detect, idle high
    always_ff @(posedge sample_clk) begin
        if (crc_reset) begin
            joy_meta <= 1'b1;
            joy_sync <= 1'b1;
            joy_prev <= 1'b1;
        end else begin
            joy_meta <= joy_in;
            joy_sync <= joy_meta;
            joy_prev <= joy_sync;
        end
    end

    assign fall_edge  = joy_prev & ~joy_sync;
    assign sample_now = (state == RX_SAMPLE) && (sample_cnt == SAMPLE_AT);

    // frame length in bits, stop bit not included
    always_comb begin
        cmd_known = 1'b1;
        case (cmd_byte)
            CMD_INFO, CMD_STATUS, CMD_RESET: frame_len = CMD_BITS;
            CMD_READ:                        frame_len = READ_FRAME;
            CMD_WRITE:                       frame_len = WRITE_FRAME;
            default: begin
                frame_len = CMD_BITS; // just skip its stop bit
                cmd_known = 1'b0;
            end
        endcase
    end

    always_ff @(posedge sample_clk) begin
        if (crc_reset) begin
            state         <= RX_IDLE;
            sample_cnt    <= '0;
            bit_cnt       <= '0;
            cur_operation <= 1'b0;
            handoff_seen  <= 1'b0;
        end else begin
            case (state)
                RX_IDLE: begin
                    if (fall_edge) begin
                        sample_cnt <= SMP_W'(1);
                        state      <= RX_SAMPLE;
                    end
                end
                RX_SAMPLE: begin
                    if (!sample_now) begin
                        sample_cnt <= sample_cnt + 1'b1;
                    end else if (bit_cnt == frame_len) begin // console stop bit
                        bit_cnt <= '0;
                        if (cmd_known) begin
                            cur_operation <= 1'b1;
                            state         <= RX_BUSY;
                        end else begin
                            state <= RX_IDLE;
                        end
                    end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                        state   <= RX_IDLE;
                    end
                end
                RX_BUSY: begin
                    if (rx_handoff != handoff_seen) begin // response done
                        handoff_seen  <= rx_handoff;
                        cur_operation <= 1'b0;
                        state         <= RX_IDLE;
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    always_ff @(posedge sample_clk) begin
        if (sample_now && (bit_cnt < CMD_BITS)) begin
            cmd_byte <= {cmd_byte[6:0], joy_sync}; // msb first
        end
    end

    assign cmd = joybus_cmd_e'(cmd_byte);

    // seed on the last command bit, feed only the write data field
    assign crc_load   = sample_now && (bit_cnt == CMD_BITS - 1'b1);
    assign crc_enable = sample_now && (cmd_byte == CMD_WRITE) &&
                        (bit_cnt >= READ_FRAME) && (bit_cnt < WRITE_FRAME);

    joybus_crc data_crc0 (
        .sample_clk (sample_clk),
        .crc_reset  (crc_reset),
        .reset_to   ('0),
        .load       (crc_load),
        .enable     (crc_enable),
        .data       (joy_sync),
        .rem        (crc)
    );

endmodule

// File: rtl/joybus_tx.sv
`timescale 1ns/1ps

`include "joybus_config.svh"

module joybus_tx (
    input  logic                    sample_clk,
    input  logic                    crc_reset,
    input  logic                    cur_operation,
    input  joybus_pkg::joybus_cmd_e cmd,
    input  joybus_pkg::crc_t        crc,
    input  logic [31:0]             buttons,
    output logic                    rx_handoff,
    output logic                    joy_out,
    output logic                    joy_drive
);
    import joybus_pkg::*;

    localparam int LW = `JOYBUS_LEVEL_WIDTH;
    localparam int BW = `JOYBUS_BIT_WIDTH;
    localparam int RESP_W = `JOYBUS_READ_RESP_BITS;
    localparam int LEN_W = $clog2(RESP_W + 1);
    localparam int LVL_W = $clog2(BW);
    localparam logic [23:0] INFO_RESP = 24'h050000; // standard pad, no pak
    localparam logic [BW-1:0] STOP_PATTERN = {{2*LW{1'b0}}, {2*LW{1'b1}}}; // L,L,H
    localparam logic [LVL_W-1:0] STOP_RELEASE = LVL_W'(3 * LW);
    localparam logic [LVL_W-1:0] LAST_LEVEL = LVL_W'(BW - 1);
    localparam logic [3:0] FLUSH_BITS = 4'd8;

    tx_state_e         state;
    logic [RESP_W-1:0] resp_buf;
    logic [LEN_W-1:0]  resp_len;
    logic [LEN_W-1:0]  bit_cnt;
    logic [LEN_W-1:0]  bit_idx;
    logic [LVL_W-1:0]  level_cnt;
    logic [3:0]        crc_cnt;
    logic              resp_done;
    logic              start;
    logic              in_stop;
    logic [BW-1:0]     cur_pattern;
    logic              flush_load;
    logic              flush_enable;
    crc_t              flush_rem;

    // four levels per bit, the first always low
    function automatic logic [BW-1:0] encode_bit(input logic b);
        if (b) begin
            return {{LW{1'b0}}, {3*LW{1'b1}}}; // L,H,H,H
        end
        return {{3*LW{1'b0}}, {LW{1'b1}}}; // L,L,L,H
    endfunction

    // resp_done holds off a restart until rx drops cur_operation
    assign start   = cur_operation && !resp_done && (state == PREPPING_RESPONSE);
    assign in_stop = (bit_cnt == resp_len);
    assign bit_idx = resp_len - bit_cnt - 1'b1;

    always_comb begin
        if (in_stop) begin
            cur_pattern = STOP_PATTERN;
        end else begin
            cur_pattern = encode_bit(resp_buf[bit_idx]);
        end
    end

    always_ff @(posedge sample_clk) begin
        if (crc_reset) begin
            state      <= PREPPING_RESPONSE;
            level_cnt  <= '0;
            bit_cnt    <= '0;
            crc_cnt    <= '0;
            resp_done  <= 1'b0;
            rx_handoff <= 1'b0;
            joy_out    <= 1'b1;
            joy_drive  <= 1'b0;
        end else begin
            case (state)
                PREPPING_RESPONSE: begin
                    level_cnt <= '0;
                    bit_cnt   <= '0;
                    crc_cnt   <= '0;
                    if (!cur_operation) begin
                        resp_done <= 1'b0;
                    end else if (start) begin
                        if (cmd == CMD_WRITE) begin
                            state <= FLUSH_CRC;
                        end else begin
                            state <= SENDING_LEVELS;
                        end
                    end
                end
                FLUSH_CRC: begin
                    if (crc_cnt == FLUSH_BITS) begin
                        state <= SENDING_LEVELS;
                    end else begin
                        crc_cnt <= crc_cnt + 1'b1;
                    end
                end
                SENDING_LEVELS: begin
                    if (in_stop && (level_cnt == STOP_RELEASE)) begin // release line
                        joy_drive  <= 1'b0;
                        joy_out    <= 1'b1;
                        rx_handoff <= ~rx_handoff;
                        resp_done  <= 1'b1;
                        state      <= PREPPING_RESPONSE;
                    end else begin
                        joy_drive <= 1'b1;
                        joy_out   <= cur_pattern[LVL_W'(BW - 1) - level_cnt];
                        if (level_cnt == LAST_LEVEL) begin
                            level_cnt <= '0;
                            bit_cnt   <= bit_cnt + 1'b1;
                        end else begin
                            level_cnt <= level_cnt + 1'b1;
                        end
                    end
                end
                default: state <= PREPPING_RESPONSE;
            endcase
        end
    end

    always_ff @(posedge sample_clk) begin
        if (start) begin
            case (cmd)
                CMD_INFO, CMD_RESET: begin
                    resp_buf <= RESP_W'(INFO_RESP);
                    resp_len <= LEN_W'(24);
                end
                CMD_STATUS: begin
                    resp_buf <= RESP_W'(buttons); // snapshot at start of reply
                    resp_len <= LEN_W'(32);
                end
                CMD_READ: begin
                    resp_buf <= '0; // no pak fitted
                    resp_len <= LEN_W'(RESP_W);
                end
                CMD_WRITE: resp_len <= LEN_W'(8);
                default: ;
            endcase
        end else if ((state == FLUSH_CRC) && (crc_cnt == FLUSH_BITS)) begin
            resp_buf <= RESP_W'(flush_rem);
        end
    end

    // seed with the rx remainder, then push 8 zeros through
    assign flush_load   = start && (cmd == CMD_WRITE);
    assign flush_enable = (state == FLUSH_CRC) && (crc_cnt < FLUSH_BITS);

    joybus_crc flush_crc0 (
        .sample_clk (sample_clk),
        .crc_reset  (crc_reset),
        .reset_to   (crc),
        .load       (flush_load),
        .enable     (flush_enable),
        .data       (1'b0),
        .rem        (flush_rem)
    );

endmodule

// File: tb/fake_n64_controller_assert.sv
`timescale 1ns/1ps

`include "joybus_config.svh"

module fake_n64_controller_assert (
    input logic                                  sample_clk,
    input logic                                  crc_reset,
    input logic                                  cur_operation,
    input logic                                  rx_handoff,
    input logic                                  joy_out,
    input logic                                  joy_drive,
    input joybus_pkg::tx_state_e                 state,
    input logic [$clog2(`JOYBUS_BIT_WIDTH)-1:0] level_cnt
);
    import joybus_pkg::*;

    int fail_count = 0; // read by the testbench at the end

    // tx may only take the line while rx hands it over
    drive_needs_operation: assert property (@(posedge sample_clk) disable iff (crc_reset)
        !cur_operation |-> !$rose(joy_drive))
    else begin
        $error("joy_drive rose while cur_operation was low");
        fail_count++;
    end

    // level 0 of every bit, stop bit included
    bit_starts_low: assert property (@(posedge sample_clk) disable iff (crc_reset)
        (state == SENDING_LEVELS && level_cnt == '0) |=> (joy_drive && !joy_out))
    else begin
        $error("a driven bit did not start with a low level");
        fail_count++;
    end

    handoff_at_release: assert property (@(posedge sample_clk) disable iff (crc_reset)
        $changed(rx_handoff) |-> $fell(joy_drive))
    else begin
        $error("rx_handoff toggled outside the release cycle");
        fail_count++;
    end

    release_toggles_handoff: assert property (@(posedge sample_clk) disable iff (crc_reset)
        $fell(joy_drive) |-> $changed(rx_handoff))
    else begin
        $error("joy_drive fell without an rx_handoff toggle");
        fail_count++;
    end

    released_line_high: assert property (@(posedge sample_clk) disable iff (crc_reset)
        !joy_drive |-> joy_out)
    else begin
        $error("joy_out was low while the line was released");
        fail_count++;
    end

endmodule

bind joybus_tx fake_n64_controller_assert tx_checks0 (
    .sample_clk    (sample_clk),
    .crc_reset     (crc_reset),
    .cur_operation (cur_operation),
    .rx_handoff    (rx_handoff),
    .joy_out       (joy_out),
    .joy_drive     (joy_drive),
    .state         (state),
    .level_cnt     (level_cnt)
);

// File: tb/fake_n64_controller_tb.sv
`timescale 1ns/1ps

`include "joybus_config.svh"

module fake_n64_controller_tb;
    import joybus_pkg::*;

    localparam int BW = `JOYBUS_BIT_WIDTH;
    localparam int LW = `JOYBUS_LEVEL_WIDTH;
    // command and reply bits of the whole run, plus the silent window
    localparam int RUN_BITS =
        3 * (8 + 24) + 3 * (8 + 32) + (24 + 264) + (280 + 8) + (8 + 40);
    localparam int TIMEOUT_CYCLES = 2 * RUN_BITS * BW + 4000;

    logic        sample_clk;
    logic        crc_reset;
    logic        joy_in;
    logic [31:0] buttons;
    logic        joy_out;
    logic        joy_drive;
    logic [31:0] lcg_state = 32'h4020;
    int          error_count = 0;
    int          cycle_count = 0;

    fake_n64_controller fake_n64_controller_inst (
        .sample_clk (sample_clk),
        .crc_reset  (crc_reset),
        .joy_in     (joy_in),
        .buttons    (buttons),
        .joy_out    (joy_out),
        .joy_drive  (joy_drive)
    );

    initial begin
        sample_clk = 1'b0;
        forever #50 sample_clk = ~sample_clk;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // zero seed, data msb first, then 8 zero bits
    function automatic crc_t crc_rule(input logic [255:0] data);
        crc_t rem;
        logic carry;
        logic in_bit;
        rem = '0;
        for (int i = 0; i < `JOYBUS_WRITE_DATA_BITS + 8; i++) begin
            in_bit = (i < `JOYBUS_WRITE_DATA_BITS) ? data[255 - i] : 1'b0;
            carry = rem[7];
            rem = {rem[6:0], in_bit};
            if (carry) begin
                rem = rem ^ `JOYBUS_CRC_POLY;
            end
        end
        return rem;
    endfunction

    task automatic drive_levels(input logic [3:0] levels); // first level in bit 3
        for (int i = 3; i >= 0; i--) begin
            repeat (LW) begin
                @(posedge sample_clk);
                joy_in <= levels[i];
            end
        end
    endtask

    task automatic send_byte(input logic [7:0] b);
        for (int i = 7; i >= 0; i--) begin
            drive_levels(b[i] ? 4'b0111 : 4'b0001);
        end
    endtask

    task automatic send_stop();
        drive_levels(4'b0111); // console stop bit leaves the line high
    endtask

    // decode one reply with joy_out sampled on the falling clock edge
    task automatic capture_response(output int nbits, output logic [263:0] value);
        logic [BW-1:0] cyc;
        int len;
        bit done;
        nbits = 0;
        value = '0;
        done = 1'b0;
        do @(negedge sample_clk); while (!joy_drive);
        while (!done) begin
            len = 0;
            cyc = '0;
            while ((len < BW) && joy_drive) begin
                cyc[len] = joy_out;
                len++;
                @(negedge sample_clk);
            end
            if (len == BW) begin
                value = {value[262:0], cyc[`JOYBUS_SAMPLE_POINT]};
                nbits++;
            end else begin
                done = 1'b1;
                assert ((len == 3 * LW) && (cyc[3*LW-1:0] == {{LW{1'b1}}, {2*LW{1'b0}}}))
                else begin
                    $display("reply did not end with the L,L,H stop bit before release");
                    error_count++;
                end
            end
        end
    endtask

    task automatic expect_reply(input string what, input int exp_bits,
                                input logic [263:0] exp_val);
        int got_bits;
        logic [263:0] got_val;
        capture_response(got_bits, got_val);
        assert (got_bits == exp_bits) else begin
            $display("Mismatch %s joy_out bit count: expected %0h, got %0h",
                     what, exp_bits, got_bits);
            error_count++;
        end
        assert (got_val == exp_val) else begin
            $display("Mismatch %s joy_out value: expected %0h, got %0h",
                     what, exp_val, got_val);
            error_count++;
        end
        repeat (4 * BW) begin // idle gap between commands
            @(negedge sample_clk);
            assert (!joy_drive && joy_out) else begin
                $display("line not released high after the %s reply", what);
                error_count++;
            end
        end
    endtask

    task automatic watch_silence(input int bits);
        repeat (bits * BW) begin
            @(negedge sample_clk);
            assert (!joy_drive) else begin
                $display("device drove the line after an unknown command");
                error_count++;
            end
        end
    endtask

    initial begin
        logic [31:0]  word;
        logic [255:0] write_data;
        int           bound_fails;
        joy_in    = 1'b1;
        buttons   = '0;
        crc_reset = 1'b1;
        repeat (16) @(posedge sample_clk);
        crc_reset <= 1'b0;
        repeat (BW) @(negedge sample_clk);
        assert (!joy_drive && joy_out) else begin
            $display("line not idle after reset");
            error_count++;
        end

        send_byte(CMD_INFO);
        send_stop();
        expect_reply("info", 24, 264'h050000);
        send_byte(CMD_RESET);
        send_stop();
        expect_reply("reset", 24, 264'h050000);

        for (int n = 0; n < 3; n++) begin
            word = lcg_next();
            @(posedge sample_clk);
            buttons <= word; // held until the reply is out
            send_byte(CMD_STATUS);
            send_stop();
            expect_reply("status", 32, word);
        end

        word = lcg_next();
        send_byte(CMD_READ);
        send_byte(word[15:8]);
        send_byte(word[7:0]);
        send_stop();
        expect_reply("read", `JOYBUS_READ_RESP_BITS, '0);

        write_data = '0;
        for (int i = 0; i < 8; i++) begin
            write_data = {write_data[223:0], lcg_next()};
        end
        word = lcg_next();
        send_byte(CMD_WRITE);
        send_byte(word[15:8]);
        send_byte(word[7:0]);
        for (int i = 31; i >= 0; i--) begin
            send_byte(write_data[i*8 +: 8]); // first byte from the top
        end
        send_stop();
        expect_reply("write", 8, crc_rule(write_data));

        send_byte(8'h7e);
        send_stop();
        watch_silence(40);
        send_byte(CMD_INFO);
        send_stop();
        expect_reply("info after unknown", 24, 264'h050000);

        bound_fails = fake_n64_controller_inst.tx0.tx_checks0.fail_count;
        $display("checks done: %0d reply errors, %0d bound assertion errors",
                 error_count, bound_fails);
        if ((error_count == 0) && (bound_fails == 0)) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    initial begin
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge sample_clk);
            cycle_count++;
        end
        $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("*** FAILED ***");
        $finish;
    end

endmodule
